//--- build.f
+incdir+include
hdl/bp_pkg.sv
hdl/fetch_pkg.sv
hdl/direction_predictor.sv
hdl/target_buffer.sv
hdl/next_ip_unit.sv
hdl/branch_frontend.sv
testbench/tb_clock.sv
testbench/tb_frontend.sv

//--- hdl/bp_pkg.sv
/* predictor state types: saturating counters, global history,
   counter table index, target buffer index and tag */
`include "frontend_defs.svh"

package bp_pkg;

  // 2-bit saturating counter, msb is the taken vote
  typedef logic [1:0] counter_t;

  // global history, newest outcome in bit 0
  typedef logic [`FE_GHIST_W-1:0] ghist_t;

  // counter table index
  typedef logic [`FE_PHT_IDX_W-1:0] pht_idx_t;

  typedef logic [`FE_BTB_IDX_W-1:0] btb_idx_t; // target buffer set
  typedef logic [`FE_BTB_TAG_W-1:0] btb_tag_t; // upper ip bits

endpackage

//--- hdl/branch_frontend.sv
/* fetch front end top: direction predictor and target buffer
   side by side, next ip unit combining them */
`timescale 1ns/1ps

module branch_frontend (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   upd_valid,
  input  fetch_pkg::fetch_addr_t upd_src_ip,
  input  fetch_pkg::fetch_addr_t upd_target,
  input  logic                   upd_taken,
  input  logic                   upd_uncond,
  input  logic                   upd_mispredict,
  input  bp_pkg::ghist_t         upd_ghist,
  input  logic                   credit_return,
  output logic                   fetch_valid,
  output fetch_pkg::fetch_addr_t fetch_addr
);
  import bp_pkg::*;
  import fetch_pkg::*;

  fetch_addr_t ip;
  ghist_t      ghist;
  logic        pred_taken;
  logic        btb_hit;
  logic        btb_uncond;
  fetch_addr_t btb_target;

  direction_predictor u_dir (
    .clk        (clk),
    .rst        (rst),
    .ip         (ip),
    .ghist      (ghist),
    .upd_valid  (upd_valid),
    .upd_taken  (upd_taken),
    .upd_src_ip (upd_src_ip),
    .upd_ghist  (upd_ghist),
    .pred_taken (pred_taken)
  );

  target_buffer u_btb (
    .clk        (clk),
    .rst        (rst),
    .ip         (ip),
    .upd_valid  (upd_valid),
    .upd_taken  (upd_taken),
    .upd_uncond (upd_uncond),
    .upd_src_ip (upd_src_ip),
    .upd_target (upd_target),
    .btb_hit    (btb_hit),
    .btb_target (btb_target),
    .btb_uncond (btb_uncond)
  );

  next_ip_unit u_nip (
    .clk            (clk),
    .rst            (rst),
    .pred_taken     (pred_taken),
    .btb_hit        (btb_hit),
    .btb_uncond     (btb_uncond),
    .btb_target     (btb_target),
    .upd_valid      (upd_valid),
    .upd_mispredict (upd_mispredict),
    .upd_taken      (upd_taken),
    .upd_src_ip     (upd_src_ip),
    .upd_target     (upd_target),
    .upd_ghist      (upd_ghist),
    .credit_return  (credit_return),
    .ip             (ip),
    .ghist          (ghist),
    .fetch_valid    (fetch_valid),
    .fetch_addr     (fetch_addr)
  );

endmodule

//--- hdl/direction_predictor.sv
/* direction predictor: three 2-bit counter tables indexed with
   0, 4 and 8 history bits, majority vote, saturating training */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module direction_predictor (
  input  logic                   clk,
  input  logic                   rst,
  input  fetch_pkg::fetch_addr_t ip,
  input  bp_pkg::ghist_t         ghist,
  input  logic                   upd_valid,
  input  logic                   upd_taken,
  input  fetch_pkg::fetch_addr_t upd_src_ip,
  input  bp_pkg::ghist_t         upd_ghist,
  output logic                   pred_taken
);
  import bp_pkg::*;

  localparam int OFS     = $clog2(`FE_BLOCK_BYTES);
  localparam int ENTRIES = 1 << `FE_PHT_IDX_W;
  localparam int TABLES  = 3;

  counter_t          pht     [TABLES][ENTRIES];
  pht_idx_t          rd_idx  [TABLES];
  pht_idx_t          upd_idx [TABLES];
  counter_t          upd_old [TABLES];
  counter_t          upd_new [TABLES];
  logic [TABLES-1:0] vote;

  // table A takes no history, B the low bits, C all of it
  function automatic pht_idx_t fold_idx(input logic [`FE_ADDR_W-1:0] addr,
                                        input ghist_t hist, input int t);
    ghist_t mask;
    case (t)
      0:       mask = '0;
      1:       mask = ghist_t'((1 << `FE_HIST_B) - 1);
      default: mask = '1;
    endcase
    return addr[OFS +: `FE_PHT_IDX_W] ^ pht_idx_t'(hist & mask);
  endfunction

  function automatic counter_t sat_step(input counter_t c, input logic up);
    if (up) begin
      return (c == 2'b11) ? c : c + 2'd1;
    end
    return (c == 2'b00) ? c : c - 2'd1;
  endfunction

  always_comb begin
    for (int t = 0; t < TABLES; t++) begin
      rd_idx[t]  = fold_idx(ip, ghist, t);
      upd_idx[t] = fold_idx(upd_src_ip, upd_ghist, t);
      upd_old[t] = pht[t][upd_idx[t]];
      upd_new[t] = sat_step(upd_old[t], upd_taken);
      vote[t]    = pht[t][rd_idx[t]][1];
    end
  end

  // two of three
  assign pred_taken = (vote[0] & vote[1]) | (vote[0] & vote[2]) | (vote[1] & vote[2]);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < TABLES; t++) begin
        for (int i = 0; i < ENTRIES; i++) begin
          pht[t][i] <= 2'b01; // weakly not taken
        end
      end
    end else if (upd_valid) begin
      for (int t = 0; t < TABLES; t++) begin
        pht[t][upd_idx[t]] <= upd_new[t];
      end
    end
  end

  // a trained counter moves toward the outcome and never wraps past 0 or 3
  for (genvar t = 0; t < TABLES; t++) begin : g_sat_chk
    a_sat_step: assert property (@(posedge clk) disable iff (rst)
      upd_valid |=> ($past(upd_taken) ?
                     pht[t][$past(upd_idx[t])] >= $past(upd_old[t]) :
                     pht[t][$past(upd_idx[t])] <= $past(upd_old[t])));
  end

endmodule

//--- hdl/fetch_pkg.sv
/* fetch stream types: block address and credit count */
`include "frontend_defs.svh"

package fetch_pkg;

  // block aligned fetch address
  typedef logic [`FE_ADDR_W-1:0] fetch_addr_t;

  // credits held by the front end, 0 .. FE_CREDITS
  typedef logic [`FE_CREDIT_W-1:0] credit_t;

endpackage

//--- hdl/next_ip_unit.sv
/* next ip unit: ip and history registers, redirect / predicted
   target / fall-through choice, fetch credit counter */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module next_ip_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   pred_taken,
  input  logic                   btb_hit,
  input  logic                   btb_uncond,
  input  fetch_pkg::fetch_addr_t btb_target,
  input  logic                   upd_valid,
  input  logic                   upd_mispredict,
  input  logic                   upd_taken,
  input  fetch_pkg::fetch_addr_t upd_src_ip,
  input  fetch_pkg::fetch_addr_t upd_target,
  input  bp_pkg::ghist_t         upd_ghist,
  input  logic                   credit_return,
  output fetch_pkg::fetch_addr_t ip,
  output bp_pkg::ghist_t         ghist,
  output logic                   fetch_valid,
  output fetch_pkg::fetch_addr_t fetch_addr
);
  import bp_pkg::*;
  import fetch_pkg::*;

  localparam credit_t     CREDITS_MAX = credit_t'(`FE_CREDITS);
  localparam fetch_addr_t BLOCK_STEP  = fetch_addr_t'(`FE_BLOCK_BYTES);

  credit_t     credits;
  credit_t     credits_next;
  logic        started;      // low through reset and the cycle after
  logic        redirect;
  logic        cond_hit;
  logic        take_branch;
  fetch_addr_t seq_ip;
  fetch_addr_t ip_next;
  ghist_t      ghist_next;

  assign redirect    = upd_valid && upd_mispredict;
  assign cond_hit    = btb_hit && !btb_uncond;
  assign take_branch = btb_hit && (btb_uncond || pred_taken);
  assign seq_ip      = ip + BLOCK_STEP;

  assign fetch_valid = started && (credits != '0);
  assign fetch_addr  = ip;

  // retire redirect beats the prediction of the block in flight
  always_comb begin
    ip_next    = ip;
    ghist_next = ghist;
    if (redirect) begin
      ip_next    = upd_taken ? upd_target : upd_src_ip + BLOCK_STEP;
      ghist_next = upd_ghist;
    end else if (fetch_valid) begin
      ip_next = take_branch ? btb_target : seq_ip;
      if (cond_hit) begin
        ghist_next = {ghist[`FE_GHIST_W-2:0], pred_taken};
      end
    end
  end

  // return and consume in one cycle cancel out
  always_comb begin
    credits_next = credits;
    if (credit_return && !fetch_valid) begin
      credits_next = credits + 1'b1;
    end else if (fetch_valid && !credit_return) begin
      credits_next = credits - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ip      <= `FE_RESET_IP;
      ghist   <= '0;
      credits <= CREDITS_MAX;
      started <= 1'b0;
    end else begin
      ip      <= ip_next;
      ghist   <= ghist_next;
      credits <= credits_next;
      started <= 1'b1;
    end
  end

  // consumer holds no credit while the count is full
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credit_return |-> credits < CREDITS_MAX);

  // once dry, fetch resumes only in the cycle after a return
  a_dry_resume: assert property (@(posedge clk) disable iff (rst)
    (started && !fetch_valid) |=> (fetch_valid == $past(credit_return)));

endmodule

//--- hdl/target_buffer.sv
/* direct mapped branch target buffer: valid, tag, target and
   unconditional flag, lookup by fetch ip, fill on taken retire */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module target_buffer (
  input  logic                   clk,
  input  logic                   rst,
  input  fetch_pkg::fetch_addr_t ip,
  input  logic                   upd_valid,
  input  logic                   upd_taken,
  input  logic                   upd_uncond,
  input  fetch_pkg::fetch_addr_t upd_src_ip,
  input  fetch_pkg::fetch_addr_t upd_target,
  output logic                   btb_hit,
  output fetch_pkg::fetch_addr_t btb_target,
  output logic                   btb_uncond
);
  import bp_pkg::*;
  import fetch_pkg::*;

  localparam int OFS     = $clog2(`FE_BLOCK_BYTES);
  localparam int ENTRIES = 1 << `FE_BTB_IDX_W;
  localparam int TAG_LSB = `FE_ADDR_W - `FE_BTB_TAG_W;

  logic [ENTRIES-1:0] valid;
  logic [ENTRIES-1:0] unc_mem;
  btb_tag_t           tag_mem [ENTRIES];
  fetch_addr_t        tgt_mem [ENTRIES];

  btb_idx_t rd_idx;
  btb_tag_t rd_tag;
  btb_idx_t wr_idx;
  btb_tag_t wr_tag;
  logic     alloc;

  assign rd_idx = ip[OFS +: `FE_BTB_IDX_W];
  assign rd_tag = ip[TAG_LSB +: `FE_BTB_TAG_W];
  assign wr_idx = upd_src_ip[OFS +: `FE_BTB_IDX_W];
  assign wr_tag = upd_src_ip[TAG_LSB +: `FE_BTB_TAG_W];

  // only taken branches get an entry, any older one in the set is replaced
  assign alloc = upd_valid && upd_taken;

  assign btb_hit    = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign btb_target = tgt_mem[rd_idx];
  assign btb_uncond = unc_mem[rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (alloc) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      tag_mem[wr_idx] <= wr_tag;
      tgt_mem[wr_idx] <= upd_target;
      unc_mem[wr_idx] <= upd_uncond;
    end
  end

endmodule

//--- include/frontend_defs.svh
/* width, table size, credit and reset vector macros
   for the branch predicting fetch front end */
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// fetch stream
`define FE_ADDR_W       32
`define FE_BLOCK_BYTES  32            // one fetch block per cycle
`define FE_RESET_IP     32'h0000_1000 // first fetch after reset

// direction predictor
`define FE_PHT_IDX_W    8  // 256 counters per table, ip[12:5]
`define FE_GHIST_W      8
`define FE_HIST_B       4  // history bits folded into table B

// target buffer, direct mapped
`define FE_BTB_IDX_W    6  // ip[10:5]
`define FE_BTB_TAG_W    21 // ip[31:11]

// fetch credits
`define FE_CREDITS      4
`define FE_CREDIT_W     3

`endif

//--- testbench/tb_clock.sv
/* testbench clock and synchronous reset source */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0; // released on a falling edge
  end

endmodule

//--- testbench/tb_frontend.sv
/* testbench for the fetch front end: DUT, credit model, directed tests
   for fetch order, back-pressure, redirects and branches, LFSR address
   source and watchdog */
`timescale 1ns/1ps
`include "frontend_defs.svh"

module tb_frontend;
  import bp_pkg::*;
  import fetch_pkg::*;

  localparam int          PERIOD_NS   = 100;
  localparam int          RST_CYCLES  = 10;
  localparam int          TEST_CYCLES = 60; // all directed tests together
  localparam int          MARGIN      = 40;
  localparam int          OFS         = $clog2(`FE_BLOCK_BYTES);
  localparam fetch_addr_t STEP        = fetch_addr_t'(`FE_BLOCK_BYTES);

  logic        clk;
  logic        rst;
  logic        upd_valid;
  fetch_addr_t upd_src_ip;
  fetch_addr_t upd_target;
  logic        upd_taken;
  logic        upd_uncond;
  logic        upd_mispredict;
  ghist_t      upd_ghist;
  logic        credit_return;
  logic        fetch_valid;
  fetch_addr_t fetch_addr;

  int          credits_m; // credits the front end should hold
  logic        obs_valid;
  fetch_addr_t obs_addr;
  fetch_addr_t seq_addr;
  logic [31:0] lfsr;

  tb_clock #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(RST_CYCLES)) clock_gen (
    .clk (clk),
    .rst (rst)
  );

  branch_frontend UUT (
    .clk            (clk),
    .rst            (rst),
    .upd_valid      (upd_valid),
    .upd_src_ip     (upd_src_ip),
    .upd_target     (upd_target),
    .upd_taken      (upd_taken),
    .upd_uncond     (upd_uncond),
    .upd_mispredict (upd_mispredict),
    .upd_ghist      (upd_ghist),
    .credit_return  (credit_return),
    .fetch_valid    (fetch_valid),
    .fetch_addr     (fetch_addr)
  );

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic compare_hex(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp)
      else fail_now($sformatf("Fail %s expected %h got %h", name, exp, got));
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_block(output fetch_addr_t a);
    fetch_addr_t bits;
    bits = '0;
    for (int i = 0; i < `FE_ADDR_W - OFS; i++) begin
      lfsr = lfsr_next(lfsr); // one step per address bit
      bits = (bits << 1) | fetch_addr_t'(lfsr[0]);
    end
    a = bits << OFS;
  endtask

  // sample on the falling edge, then drive the inputs of the next rising edge
  task automatic next_cycle(input logic ret);
    @(negedge clk);
    upd_valid      = 1'b0;
    upd_mispredict = 1'b0;
    obs_valid      = fetch_valid;
    obs_addr       = fetch_addr;
    compare_hex("fetch_valid", credits_m != 0, obs_valid);
    credit_return = ret;
    if (ret && !obs_valid) begin
      credits_m++;
    end else if (!ret && obs_valid) begin
      credits_m--;
    end
  endtask

  // consumer hands back every credit it can
  task automatic flow_cycle();
    next_cycle(credits_m < `FE_CREDITS);
  endtask

  task automatic expect_fetch(input fetch_addr_t addr);
    flow_cycle();
    compare_hex("fetch_valid", 1, obs_valid);
    compare_hex("fetch_addr", addr, obs_addr);
  endtask

  task automatic resume_flow();
    int n;
    n = 0;
    flow_cycle();
    while (!obs_valid && n < 8) begin
      flow_cycle();
      n++;
    end
    assert (obs_valid) else fail_now("fetch did not resume after credits came back");
  endtask

  task automatic drive_update(input fetch_addr_t src, input fetch_addr_t tgt,
                              input logic taken, input logic uncond,
                              input logic mispredict, input ghist_t hist);
    upd_valid      = 1'b1;
    upd_src_ip     = src;
    upd_target     = tgt;
    upd_taken      = taken;
    upd_uncond     = uncond;
    upd_mispredict = mispredict;
    upd_ghist      = hist;
  endtask

  // not-taken mispredict one block before, so no target buffer write
  task automatic redirect_to(input fetch_addr_t addr);
    drive_update(addr - STEP, '0, 1'b0, 1'b0, 1'b1, '0);
  endtask

  task automatic reset_and_sequential_fetch();
    @(posedge clk);
    repeat (RST_CYCLES - 1) begin
      @(negedge clk);
      compare_hex("fetch_valid", 0, fetch_valid);
    end
    wait (rst == 1'b0);
    for (int i = 0; i < `FE_CREDITS; i++) begin
      next_cycle(1'b0);
      compare_hex("fetch_valid", 1, obs_valid);
      compare_hex("fetch_addr", `FE_RESET_IP + i * `FE_BLOCK_BYTES, obs_addr);
    end
    seq_addr = `FE_RESET_IP + `FE_CREDITS * `FE_BLOCK_BYTES;
  endtask

  task automatic credit_back_pressure();
    repeat (5) begin
      next_cycle(1'b0);
      compare_hex("fetch_valid", 0, obs_valid);
    end
    repeat (3) begin
      next_cycle(1'b1);
      next_cycle(1'b0);
      compare_hex("fetch_valid", 1, obs_valid);
      compare_hex("fetch_addr", seq_addr, obs_addr);
      seq_addr = seq_addr + STEP;
      next_cycle(1'b0);
      compare_hex("fetch_valid", 0, obs_valid);
    end
  endtask

  task automatic mispredict_redirect();
    fetch_addr_t src;
    fetch_addr_t tgt;
    random_block(src);
    random_block(tgt);
    resume_flow();
    compare_hex("fetch_addr", seq_addr, obs_addr);
    drive_update(src, tgt, 1'b1, 1'b0, 1'b1, '0);
    expect_fetch(tgt);
    expect_fetch(tgt + STEP);
    random_block(src);
    drive_update(src, tgt, 1'b0, 1'b0, 1'b1, 8'h5a);
    expect_fetch(src + STEP);
    expect_fetch(src + 2 * STEP);
  endtask

  task automatic unconditional_branch();
    fetch_addr_t src;
    fetch_addr_t tgt;
    random_block(src);
    random_block(tgt);
    drive_update(src, tgt, 1'b1, 1'b1, 1'b0, '0); // train only
    flow_cycle();
    redirect_to(src);
    expect_fetch(src);
    expect_fetch(tgt);
    expect_fetch(tgt + STEP);
  endtask

  task automatic conditional_branch();
    fetch_addr_t src;
    fetch_addr_t tgt;
    random_block(src);
    random_block(tgt);
    redirect_to(src);
    expect_fetch(src);
    expect_fetch(src + STEP); // untrained
    // history 11 moves table B and C writes off the zero history index
    drive_update(src, tgt, 1'b1, 1'b0, 1'b0, 8'h11);
    flow_cycle();
    redirect_to(src);
    expect_fetch(src);
    expect_fetch(src + STEP); // only table A votes taken
    drive_update(src, tgt, 1'b1, 1'b0, 1'b0, '0);
    flow_cycle();
    redirect_to(src);
    expect_fetch(src);
    expect_fetch(tgt);
  endtask

  initial begin
    credits_m      = `FE_CREDITS;
    lfsr           = 32'hae20_0d7d;
    upd_valid      = 1'b0;
    upd_src_ip     = '0;
    upd_target     = '0;
    upd_taken      = 1'b0;
    upd_uncond     = 1'b0;
    upd_mispredict = 1'b0;
    upd_ghist      = '0;
    credit_return  = 1'b0;
    reset_and_sequential_fetch();
    credit_back_pressure();
    mispredict_redirect();
    unconditional_branch();
    conditional_branch();
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #((RST_CYCLES + TEST_CYCLES + MARGIN) * PERIOD_NS);
    fail_now("run timed out before the directed tests finished");
  end

endmodule
